// File: dv/driveLinkTb.sv
`include "driveLink_macros.svh"

module driveLinkTb import driveLinkPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam time ClkPeriod   = 100;
    localparam int  FrameClks   = 10 * `DRIVE_CLKS_PER_BIT;
    localparam int  ByteTimeout = 2 * FrameClks + `DRIVE_MSG_GAP;
    localparam int  DoneTimeout = `DRIVE_CLKS_PER_BIT;
    localparam int  NumMsgs     = 12;  // Eight fixed codes, then random ones
    localparam int  IdxW        = $clog2(`DRIVE_MAX_MSG_LEN + 1);

    logic            clk;
    logic            rst;
    logic [2:0]      modeSel;
    logic            txd;
    logic            msgDone;
    logic [IdxW-1:0] msgLen;

    logic [7:0] byteQ[$];       // Decoded, not yet checked
    time        startQ[$];
    logic       goodQ[$];
    int         rxTotal   = 0;  // Bytes decoded since reset
    int         rxAtDone  = 0;  // rxTotal at the latest msgDone
    int         lastCount = 0;  // Bytes between the last two msgDone pulses
    int         doneCount = 0;
    time        doneTime  = 0;
    integer     seed;

    driveLinkTop i_driveLinkTop (
        .clk    (clk),
        .rst    (rst),
        .modeSel(modeSel),
        .txd    (txd),
        .msgDone(msgDone),
        .msgLen (msgLen)
    );

    uartMonitor i_uartMonitor (
        .clk(clk),
        .rst(rst),
        .txd(txd)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic stopWithFail();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic reportMismatch(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        stopWithFail();
    endtask

    task automatic reportStall(input string what);
        $display("Timeout: %s", what);
        stopWithFail();
    endtask

    // Wheel speed text for each drive mode
    function automatic string leftSpeed(input driveMode_e code);
        case (code)
            modeStop:      return "0";
            modeLeft:      return "-0.00";
            modeRight:     return "0.12";
            modeFwdSlow:   return "0.05";
            modeFwdMedium: return "0.25";
            modeFwdFast:   return "0.5";
            modeReverse:   return "-0.25";
            default:       return "-0.00";  // Spin left
        endcase
    endfunction

    function automatic string rightSpeed(input driveMode_e code);
        case (code)
            modeStop:      return "0";
            modeLeft:      return "0.12";
            modeRight:     return "-0.00";
            modeFwdSlow:   return "0.05";
            modeFwdMedium: return "0.25";
            modeFwdFast:   return "0.5";
            default:       return "-0.25";  // Reverse and spin left
        endcase
    endfunction

    always @(i_uartMonitor.byteRcvd) begin
        byteQ.push_back(i_uartMonitor.rxByte);
        startQ.push_back(i_uartMonitor.rxStart);
        goodQ.push_back(i_uartMonitor.rxGood);
        rxTotal++;
    end

    // Reset behavior and msgDone bookkeeping
    always @(negedge clk) begin
        assert (txd === 1'b0 || txd === 1'b1) else reportMismatch("txd is unknown");
        if (rst) begin
            assert (txd === 1'b1) else reportMismatch("txd not idle high during reset");
        end
        if (rst || rxTotal == 0) begin
            assert (msgDone === 1'b0) else reportMismatch("msgDone before any byte was sent");
        end
        if (!rst && msgDone === 1'b1) begin
            lastCount = rxTotal - rxAtDone;
            rxAtDone  = rxTotal;
            doneTime  = $time;
            doneCount++;
        end
    end

    task automatic waitByte(output logic [7:0] b, output time t, output logic good);
        int n;
        n = 0;
        while (byteQ.size() == 0) begin
            @(negedge clk);
            n++;
            if (n > ByteTimeout) begin
                reportStall("no byte was decoded from txd");
            end
        end
        b    = byteQ.pop_front();
        t    = startQ.pop_front();
        good = goodQ.pop_front();
    endtask

    initial begin
        string      lStr;
        string      rStr;
        string      expMsg;
        driveMode_e code;
        int         expLen;
        int         n;
        logic [7:0] gotByte;
        time        gotStart;
        time        prevStart;
        logic       gotGood;
        integer     draw;

        seed      = 32'h174b_23e1;
        prevStart = 0;
        rst       = 1'b1;
        modeSel   = 3'd0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        for (int m = 0; m < NumMsgs; m++) begin
            code   = driveMode_e'(modeSel);  // Steady across the sample point
            lStr   = leftSpeed(code);
            rStr   = rightSpeed(code);
            expLen = 18 + lStr.len() + rStr.len();
            expMsg = {"{\"T\":1,\"L\":", lStr, ",\"R\":", rStr, "}\n"};
            for (int i = 0; i < expLen; i++) begin
                waitByte(gotByte, gotStart, gotGood);
                assert (gotGood) else reportMismatch($sformatf(
                    "message %0d byte %0d has a bad start, stop or bit period", m, i));
                assert (gotByte == expMsg[i]) else reportMismatch($sformatf(
                    "message %0d byte %0d is 8'h%02h, expected 8'h%02h",
                    m, i, gotByte, expMsg[i]));
                assert (msgLen == expLen) else reportMismatch($sformatf(
                    "msgLen is %0d during message %0d, expected %0d", msgLen, m, expLen));
                if (i > 0) begin
                    // Frames follow back to back without an idle bit
                    assert (gotStart == prevStart + FrameClks * ClkPeriod)
                        else reportMismatch($sformatf(
                            "message %0d byte %0d does not follow the previous frame", m, i));
                end else if (m > 0) begin
                    assert (gotStart - doneTime >= `DRIVE_MSG_GAP * ClkPeriod)
                        else reportMismatch($sformatf(
                            "message %0d starts too soon after msgDone", m));
                end
                prevStart = gotStart;
                if (i == 2) begin
                    // Mid-message change reaches only the next record
                    if (m < 7) begin
                        draw = m + 1;
                    end else begin
                        draw = $random(seed);
                    end
                    modeSel = draw[2:0];
                end
            end

            n = 0;
            while (doneCount == m) begin
                @(negedge clk);
                n++;
                if (n > DoneTimeout) begin
                    reportStall($sformatf("msgDone never came after message %0d", m));
                end
            end
            assert (lastCount == expLen) else reportMismatch($sformatf(
                "message %0d had %0d bytes, expected %0d", m, lastCount, expLen));
            assert (byteQ.size() == 0) else reportMismatch($sformatf(
                "extra bytes arrived before msgDone of message %0d", m));
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: dv/uartMonitor.sv
`include "driveLink_macros.svh"

module uartMonitor (
    input logic clk,
    input logic rst,
    input logic txd   // Serial line from the DUT
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BitClks   = `DRIVE_CLKS_PER_BIT;
    localparam int FrameClks = 10 * BitClks;  // Start, eight data, stop

    event       byteRcvd;   // Fires at the end of each stop bit
    logic [7:0] rxByte;     // Last decoded byte
    time        rxStart;    // Time its start bit was first seen
    logic       rxGood;     // Start low, stop high, no bit moved mid-period

    logic       busy;       // Inside a frame
    int         cnt;        // Cycles into the frame
    logic       bitLevel;   // Level at the first cycle of the current bit
    logic [9:0] frameBits;  // Mid-bit samples, start bit at index 0
    logic       steady;
    time        startTime;

    // Outputs change on the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (rst) begin
            busy = 1'b0;
        end else begin
            if (!busy && txd === 1'b0) begin
                busy      = 1'b1;  // First cycle of a start bit
                cnt       = 0;
                steady    = 1'b1;
                startTime = $time;
            end
            if (busy) begin
                if (cnt % BitClks == 0) begin
                    bitLevel = txd;  // Bit boundary
                end else if (txd !== bitLevel) begin
                    steady = 1'b0;  // Edge inside a bit period
                end
                if (cnt % BitClks == BitClks / 2) begin
                    frameBits[cnt / BitClks] = txd;  // Mid-bit sample
                end
                if (cnt == FrameClks - 1) begin
                    rxByte  = frameBits[8:1];  // LSB came first
                    rxStart = startTime;
                    rxGood  = steady && frameBits[0] === 1'b0 && frameBits[9] === 1'b1;
                    busy    = 1'b0;  // Next start may follow at once
                    -> byteRcvd;
                end else begin
                    cnt++;
                end
            end
        end
    end

endmodule

// File: filelist.f
+incdir+logic
logic/driveLinkPkg.sv
logic/commandLatch.sv
logic/byteSequencer.sv
logic/jsonFormatter.sv
logic/uartSerializer.sv
logic/driveLinkTop.sv
dv/uartMonitor.sv
dv/driveLinkTb.sv

// File: logic/byteSequencer.sv
`include "driveLink_macros.svh"

module byteSequencer
    import driveLinkPkg::*;
#(
    localparam int IdxW = $clog2(`DRIVE_MAX_MSG_LEN + 1)
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            msgStart,   // From command latch
    input  logic [IdxW-1:0] msgLen,     // Bytes in the latched message
    input  logic            slotFree,   // Formatter holding slot empty
    input  logic            byteSent,   // End of a stop bit
    output logic            fetch,      // One cycle, byteIndex valid
    output logic [IdxW-1:0] byteIndex,  // Position in the record
    output logic            msgDone     // One cycle after last stop bit
);

    seqState_e       state;
    logic [IdxW-1:0] fetchCnt;  // Bytes handed to the formatter
    logic [IdxW-1:0] sentCnt;   // Bytes fully on the line
    logic            lastSent;  // Stop bit of final byte done

    assign lastSent = byteSent && (sentCnt == msgLen - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= seqIdle;
            fetchCnt  <= '0;
            sentCnt   <= '0;
            fetch     <= 1'b0;
            byteIndex <= '0;
            msgDone   <= 1'b0;
        end else begin
            fetch   <= 1'b0;  // Both outputs are pulses
            msgDone <= 1'b0;

            if (byteSent) begin
                sentCnt <= sentCnt + 1'b1;
            end

            case (state)
                seqIdle: begin
                    if (msgStart) begin
                        // First byte goes out without waiting for slotFree
                        fetch     <= 1'b1;
                        byteIndex <= '0;
                        fetchCnt  <= IdxW'(1);
                        sentCnt   <= '0;
                        state     <= seqFetch;
                    end
                end

                seqFetch: begin
                    if (fetchCnt == msgLen) begin
                        state <= seqDrain;  // Whole record fetched
                    end else if (slotFree && !fetch) begin
                        // !fetch guards the cycle before the slot fills
                        fetch     <= 1'b1;
                        byteIndex <= fetchCnt;
                        fetchCnt  <= fetchCnt + 1'b1;
                    end
                end

                seqDrain: begin
                    if (lastSent) begin
                        msgDone <= 1'b1;
                        state   <= seqIdle;
                    end
                end

                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

endmodule

// File: logic/commandLatch.sv
`include "driveLink_macros.svh"

module commandLatch
    import driveLinkPkg::*;
#(
    localparam int GapW = $clog2(`DRIVE_MSG_GAP + 1)
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] modeSel,   // Raw selector, may change any time
    input  logic       msgDone,   // Last byte of current message sent
    output driveMode_e mode,      // Held for the whole message
    output logic       msgStart   // One cycle, new message begins
);

    // Loaded so that msgStart lands GAP+1 cycles after msgDone
    localparam logic [GapW-1:0] GapReload = GapW'(`DRIVE_MSG_GAP - 1);

    logic [GapW-1:0] gapCnt;  // Remaining idle cycles
    logic            armed;   // Gap running, next message pending

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gapCnt   <= '0;        // Empty gap, start right away
            armed    <= 1'b1;
            msgStart <= 1'b0;
            mode     <= modeStop;
        end else begin
            msgStart <= 1'b0;  // Pulse only
            if (msgDone) begin
                gapCnt <= GapReload;  // Restart gap
                armed  <= 1'b1;
            end else if (armed) begin
                if (gapCnt == '0) begin
                    // Only place the mode may change
                    mode     <= driveMode_e'(modeSel);
                    msgStart <= 1'b1;
                    armed    <= 1'b0;  // Stay quiet until msgDone
                end else begin
                    gapCnt <= gapCnt - 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/driveLinkPkg.sv
package driveLinkPkg;

    // Motion commands coded as on the selector switches
    typedef enum logic [2:0] {
        modeStop      = 3'd0,  // L 0, R 0
        modeLeft      = 3'd1,  // L -0.00, R 0.12
        modeRight     = 3'd2,  // L 0.12, R -0.00
        modeFwdSlow   = 3'd3,  // Both wheels 0.05
        modeFwdMedium = 3'd4,  // Both wheels 0.25
        modeFwdFast   = 3'd5,  // Both wheels 0.5
        modeReverse   = 3'd6,  // Both wheels -0.25
        modeSpinLeft  = 3'd7   // L -0.00, R -0.25
    } driveMode_e;

    // Byte sequencer
    typedef enum logic [1:0] {
        seqIdle  = 2'd0,  // Waiting for message start
        seqFetch = 2'd1,  // Fetching bytes ahead of the line
        seqDrain = 2'd2   // All fetched, waiting on last stop bits
    } seqState_e;

    // UART serializer
    typedef enum logic [1:0] {
        serIdle  = 2'd0,  // Line high
        serStart = 2'd1,  // Start bit, line low
        serData  = 2'd2,  // Eight data bits, LSB first
        serStop  = 2'd3   // Stop bit, line high
    } serState_e;

endpackage

// File: logic/driveLinkTop.sv
`include "driveLink_macros.svh"

module driveLinkTop
    import driveLinkPkg::*;
#(
    localparam int IdxW = $clog2(`DRIVE_MAX_MSG_LEN + 1)
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [2:0]      modeSel,  // Motion command selector
    output logic            txd,      // UART TX, 8N1
    output logic            msgDone,  // One record finished
    output logic [IdxW-1:0] msgLen    // Length of latched record
);

    driveMode_e      mode;
    logic            msgStart;
    logic            fetch;
    logic [IdxW-1:0] byteIndex;
    logic            slotFree;
    logic [7:0]      txByte;
    logic            byteReady;
    logic            take;
    logic            byteSent;

    commandLatch i_commandLatch (
        .clk     (clk),
        .rst     (rst),
        .modeSel (modeSel),
        .msgDone (msgDone),
        .mode    (mode),
        .msgStart(msgStart)
    );

    byteSequencer i_byteSequencer (
        .clk      (clk),
        .rst      (rst),
        .msgStart (msgStart),
        .msgLen   (msgLen),
        .slotFree (slotFree),
        .byteSent (byteSent),
        .fetch    (fetch),
        .byteIndex(byteIndex),
        .msgDone  (msgDone)
    );

    jsonFormatter i_jsonFormatter (
        .clk      (clk),
        .rst      (rst),
        .mode     (mode),
        .fetch    (fetch),
        .byteIndex(byteIndex),
        .take     (take),
        .msgLen   (msgLen),
        .txByte   (txByte),
        .byteReady(byteReady),
        .slotFree (slotFree)
    );

    uartSerializer #(
        .ClksPerBit(`DRIVE_CLKS_PER_BIT)  // 115200 baud from 50 MHz
    ) i_uartSerializer (
        .clk      (clk),
        .rst      (rst),
        .txByte   (txByte),
        .byteReady(byteReady),
        .take     (take),
        .byteSent (byteSent),
        .txd      (txd)
    );

endmodule

// File: logic/driveLink_macros.svh
`ifndef DRIVELINK_MACROS_SVH
`define DRIVELINK_MACROS_SVH

// 50 MHz clock at 115200 baud
`define DRIVE_CLKS_PER_BIT 434

// Idle cycles between message end and next mode sample
`define DRIVE_MSG_GAP 2000

// Longest record length of reverse and spin left
`define DRIVE_MAX_MSG_LEN 28

`endif

// File: logic/jsonFormatter.sv
`include "driveLink_macros.svh"

module jsonFormatter
    import driveLinkPkg::*;
#(
    localparam int IdxW = $clog2(`DRIVE_MAX_MSG_LEN + 1)
) (
    input  logic            clk,
    input  logic            rst,
    input  driveMode_e      mode,       // Latched motion command
    input  logic            fetch,      // Load byte at byteIndex
    input  logic [IdxW-1:0] byteIndex,
    input  logic            take,       // Serializer copied txByte
    output logic [IdxW-1:0] msgLen,     // 18 plus both speed strings
    output logic [7:0]      txByte,
    output logic            byteReady,  // Holding slot full
    output logic            slotFree
);

    // Record is {"T":1,"L":<left>,"R":<right>} plus newline
    localparam int PrefixLen = 11;
    localparam int MidLen    = 5;
    localparam logic [8*PrefixLen-1:0] Prefix = "{\"T\":1,\"L\":";
    localparam logic [8*MidLen-1:0]    Mid    = ",\"R\":";

    logic [39:0]     leftStr;   // Left-justified, up to five chars
    logic [39:0]     rightStr;
    logic [2:0]      leftLen;
    logic [2:0]      rightLen;
    logic [IdxW-1:0] leftEnd;   // First index past left string
    logic [IdxW-1:0] midEnd;    // First index of right string
    logic [IdxW-1:0] rightEnd;  // Index of closing brace
    logic [IdxW-1:0] relIdx;    // Offset inside current field
    logic [7:0]      nextByte;

    function automatic logic [7:0] speedChar(input logic [39:0] str, input logic [2:0] pos);
        return str[8*(4-pos) +: 8];  // Char 0 sits in the top byte
    endfunction

    // Wheel speed strings per mode
    always_comb begin
        case (mode)
            modeStop: begin
                leftStr  = {"0", 32'h0};
                leftLen  = 3'd1;
                rightStr = {"0", 32'h0};
                rightLen = 3'd1;
            end
            modeLeft: begin
                leftStr  = "-0.00";
                leftLen  = 3'd5;
                rightStr = {"0.12", 8'h0};
                rightLen = 3'd4;
            end
            modeRight: begin
                leftStr  = {"0.12", 8'h0};
                leftLen  = 3'd4;
                rightStr = "-0.00";
                rightLen = 3'd5;
            end
            modeFwdSlow: begin
                leftStr  = {"0.05", 8'h0};
                leftLen  = 3'd4;
                rightStr = {"0.05", 8'h0};
                rightLen = 3'd4;
            end
            modeFwdMedium: begin
                leftStr  = {"0.25", 8'h0};
                leftLen  = 3'd4;
                rightStr = {"0.25", 8'h0};
                rightLen = 3'd4;
            end
            modeFwdFast: begin
                leftStr  = {"0.5", 16'h0};
                leftLen  = 3'd3;
                rightStr = {"0.5", 16'h0};
                rightLen = 3'd3;
            end
            modeReverse: begin
                leftStr  = "-0.25";
                leftLen  = 3'd5;
                rightStr = "-0.25";
                rightLen = 3'd5;
            end
            default: begin  // modeSpinLeft
                leftStr  = "-0.00";
                leftLen  = 3'd5;
                rightStr = "-0.25";
                rightLen = 3'd5;
            end
        endcase
    end

    assign leftEnd  = IdxW'(PrefixLen) + IdxW'(leftLen);
    assign midEnd   = leftEnd + IdxW'(MidLen);
    assign rightEnd = midEnd + IdxW'(rightLen);
    assign msgLen   = rightEnd + IdxW'(2);  // Brace and newline

    // Template lookup, field by field
    always_comb begin
        relIdx = '0;
        if (byteIndex < IdxW'(PrefixLen)) begin
            nextByte = Prefix[8*(PrefixLen-1-byteIndex) +: 8];
        end else if (byteIndex < leftEnd) begin
            relIdx   = byteIndex - IdxW'(PrefixLen);
            nextByte = speedChar(leftStr, relIdx[2:0]);
        end else if (byteIndex < midEnd) begin
            relIdx   = byteIndex - leftEnd;
            nextByte = Mid[8*(MidLen-1-relIdx) +: 8];
        end else if (byteIndex < rightEnd) begin
            relIdx   = byteIndex - midEnd;
            nextByte = speedChar(rightStr, relIdx[2:0]);
        end else if (byteIndex == rightEnd) begin
            nextByte = 8'h7D;  // Closing brace
        end else begin
            nextByte = 8'h0A;  // Newline ends the record
        end
    end

    // One-entry holding slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byteReady <= 1'b0;
        end else if (fetch) begin
            byteReady <= 1'b1;
        end else if (take) begin
            byteReady <= 1'b0;  // Serializer has its copy
        end
    end

    always_ff @(posedge clk) begin
        if (fetch) begin
            txByte <= nextByte;
        end
    end

    assign slotFree = ~byteReady;

endmodule

// File: logic/uartSerializer.sv
module uartSerializer
    import driveLinkPkg::*;
#(
    parameter int ClksPerBit = 434
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] txByte,     // From formatter slot
    input  logic       byteReady,  // Slot holds a byte
    output logic       take,       // Byte copied this cycle
    output logic       byteSent,   // Last cycle of stop bit
    output logic       txd         // Serial line, idle high
);

    localparam int CntW = $clog2(ClksPerBit);

    serState_e       state;
    logic [CntW-1:0] bitCnt;    // Cycles into current bit
    logic [2:0]      bitIdx;    // Data bit on the line
    logic [7:0]      shiftReg;  // Bit 0 is next on the line
    logic            bitDone;   // Last cycle of a bit period

    assign bitDone  = (bitCnt == CntW'(ClksPerBit - 1));
    assign byteSent = (state == serStop) && bitDone;
    // Next start bit follows the stop bit directly when a byte waits
    assign take     = byteReady && ((state == serIdle) || byteSent);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= serIdle;
            bitCnt <= '0;
            bitIdx <= '0;
            txd    <= 1'b1;  // Line idles high
        end else if (take) begin
            state  <= serStart;
            bitCnt <= '0;
            txd    <= 1'b0;  // Start bit
        end else begin
            case (state)
                serIdle: begin
                    txd <= 1'b1;
                end
                serStart: begin
                    if (bitDone) begin
                        bitCnt <= '0;
                        bitIdx <= '0;
                        txd    <= shiftReg[0];  // LSB first
                        state  <= serData;
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                serData: begin
                    if (bitDone) begin
                        bitCnt <= '0;
                        if (bitIdx == 3'd7) begin
                            txd   <= 1'b1;  // Stop bit
                            state <= serStop;
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                            txd    <= shiftReg[1];  // Next bit before the shift lands
                        end
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                default: begin  // serStop
                    if (bitDone) begin
                        bitCnt <= '0;
                        state  <= serIdle;
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (take) begin
            shiftReg <= txByte;
        end else if (state == serData && bitDone) begin
            shiftReg <= {1'b0, shiftReg[7:1]};
        end
    end

endmodule
